// ==== verilog/sb_defines.svh ====
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// Store buffer sizing. The depth is expected to be a power of two so that
// the head and tail pointers wrap on their own.

// Number of store buffer entries.
`define SB_SIZE 4

// Word address width, giving 64 RAM words.
`define SB_ADDR_W 6

// Data word width in bits.
`define SB_DATA_W 32

// One strobe bit per byte of the data word.
`define SB_STRB_W (`SB_DATA_W / 8)

`endif

// ==== verilog/sb_pkg.sv ====
`default_nettype none

`include "sb_defines.svh"

package sb_pkg;

    // One committed store, held in the buffer or on its way to the RAM.
    typedef struct packed {
        logic [`SB_ADDR_W-1:0] addr;   // Word address.
        logic [`SB_DATA_W-1:0] data;   // Write data.
        logic [`SB_STRB_W-1:0] strb;   // One bit per byte to be written.
        logic                  valid;  // Entry holds a live store.
    } sb_entry_t;

    // A load request only needs its word address.
    typedef struct packed {
        logic [`SB_ADDR_W-1:0] addr;
    } load_req_t;

    // Load response as returned to the core.
    typedef struct packed {
        logic [`SB_DATA_W-1:0] data;      // RAM word with forwarded bytes merged in.
        logic [`SB_STRB_W-1:0] fwd_mask;  // Bytes that came from the buffer.
    } load_rsp_t;

    // Result of the buffer search for one load address.
    typedef struct packed {
        logic [`SB_DATA_W-1:0] data;  // Forwarded bytes, zero where there is no hit.
        logic [`SB_STRB_W-1:0] hit;   // Set where a buffered store supplies the byte.
    } fwd_t;

endpackage

`default_nettype wire

// ==== verilog/storebuffer.sv ====
`default_nettype none

`include "sb_defines.svh"

module storebuffer
    import sb_pkg::*;
#(
    parameter int unsigned SB_SIZE = `SB_SIZE
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      flush,
    input  wire logic                      st_valid,
    input  wire sb_entry_t                 st,
    output logic                           st_ready,
    output logic                           wr_valid,
    output sb_entry_t                      wr,
    input  wire logic                      wr_ready,
    output sb_entry_t [SB_SIZE-1:0]        entries
);

    localparam int unsigned PTR_W = $clog2(SB_SIZE);  // Depth must be a power of two.

    logic [PTR_W-1:0]   head_q;   // Next slot to be written.
    logic [PTR_W-1:0]   tail_q;   // Oldest live entry.
    logic [PTR_W:0]     cnt_q;    // Number of live entries.
    logic [SB_SIZE-1:0] vld_q;    // Per-slot valid bits.
    sb_entry_t          mem [SB_SIZE];  // Store payloads, indexed by slot.

    logic push;
    logic pop;

    assign push = st_valid & st_ready & ~flush;  // A store offered during flush is dropped.
    assign pop  = wr_valid & wr_ready;

    assign st_ready = (cnt_q < (PTR_W + 1)'(SB_SIZE));

    // The oldest entry is offered to the RAM. Flush discards it along with the rest.
    assign wr_valid = vld_q[tail_q] & ~flush;

    always_comb begin
        wr       = mem[tail_q];
        wr.valid = vld_q[tail_q];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (flush) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                head_q <= head_q + 1'b1;  // Wraps at the buffer depth.
            end
            if (pop) begin
                tail_q <= tail_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // Both or neither leave the count as is.
            endcase
        end
    end

    // Push and pop never hit the same slot: a pop needs a live entry at tail,
    // and a push with live entries and room left lands elsewhere.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (flush) begin
            vld_q <= '0;
        end else begin
            if (push) begin
                vld_q[head_q] <= 1'b1;
            end
            if (pop) begin
                vld_q[tail_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[head_q] <= st;
        end
    end

    // Rotate the slots so index 0 is the oldest entry and the last index the newest.
    always_comb begin
        logic [PTR_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < SB_SIZE; i++) begin
            idx              = tail_q + PTR_W'(i);
            entries[i]       = mem[idx];
            entries[i].valid = vld_q[idx];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sb_forward.sv ====
`default_nettype none

`include "sb_defines.svh"

module sb_forward
    import sb_pkg::*;
(
    input  wire sb_entry_t [`SB_SIZE-1:0] entries,
    input  wire logic [`SB_ADDR_W-1:0]    addr,
    output fwd_t                          fwd
);

    logic [`SB_SIZE-1:0] match;  // Live entries that target the load word.

    always_comb begin
        for (int i = 0; i < `SB_SIZE; i++) begin
            match[i] = entries[i].valid & (entries[i].addr == addr);
        end
    end

    // Each byte lane is resolved on its own. Entries are walked oldest first,
    // so a later match overwrites an earlier one and the newest store wins.
    always_comb begin
        fwd = '0;
        for (int b = 0; b < `SB_STRB_W; b++) begin
            for (int i = 0; i < `SB_SIZE; i++) begin
                if (match[i] && entries[i].strb[b]) begin
                    fwd.data[8*b +: 8] = entries[i].data[8*b +: 8];
                    fwd.hit[b]         = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_unit.sv ====
`default_nettype none

`include "sb_defines.svh"

module load_unit
    import sb_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     ld_valid,
    input  wire load_req_t                ld,
    input  wire sb_entry_t [`SB_SIZE-1:0] entries,
    output logic                          rd_en,
    output logic [`SB_ADDR_W-1:0]         rd_addr,
    input  wire logic [`SB_DATA_W-1:0]    rd_data,
    output logic                          rsp_valid,
    output load_rsp_t                     rsp
);

    fwd_t fwd;    // Search result in the request cycle.
    fwd_t fwd_q;  // Same result, aligned with the RAM read data.

    sb_forward u_forward (
        .entries (entries),
        .addr    (ld.addr),
        .fwd     (fwd)
    );

    // The RAM read goes out in the request cycle. Its data returns on the next one.
    assign rd_en   = ld_valid;
    assign rd_addr = ld.addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= ld_valid;
        end
    end

    // No drain happens in a load cycle, so this snapshot matches the RAM read.
    always_ff @(posedge clk) begin
        if (ld_valid) begin
            fwd_q <= fwd;
        end
    end

    // Buffered bytes are newer than the RAM and take priority lane by lane.
    always_comb begin
        for (int b = 0; b < `SB_STRB_W; b++) begin
            if (fwd_q.hit[b]) begin
                rsp.data[8*b +: 8] = fwd_q.data[8*b +: 8];
            end else begin
                rsp.data[8*b +: 8] = rd_data[8*b +: 8];
            end
        end
        rsp.fwd_mask = fwd_q.hit;
    end

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
`default_nettype none

`include "sb_defines.svh"

module data_ram
    import sb_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rd_en,
    input  wire logic [`SB_ADDR_W-1:0] rd_addr,
    output logic [`SB_DATA_W-1:0]      rd_data,
    input  wire logic                  wr_valid,
    input  wire sb_entry_t             wr,
    output logic                       wr_ready
);

    localparam int unsigned DEPTH = 2 ** `SB_ADDR_W;

    logic [`SB_DATA_W-1:0] mem [DEPTH];
    logic                  wr_en;

    // One port only. A load owns it for the cycle and the drain waits.
    assign wr_ready = ~rd_en;
    assign wr_en    = wr_valid & wr_ready;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // Held until the next read.
        end
    end

    // Only strobed bytes change; the rest of the word keeps its old value.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `SB_STRB_W; b++) begin
                if (wr.strb[b]) begin
                    mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/store_unit.sv ====
`default_nettype none

`include "sb_defines.svh"

module store_unit
    import sb_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      flush,
    input  wire logic      st_valid,
    input  wire sb_entry_t st,
    output logic           st_ready,
    input  wire logic      ld_valid,
    input  wire load_req_t ld,
    output logic           rsp_valid,
    output load_rsp_t      rsp
);

    logic                        wr_valid;
    logic                        wr_ready;
    sb_entry_t                   wr;       // Oldest store on its way to the RAM.
    sb_entry_t [`SB_SIZE-1:0]    entries;  // Buffer contents, oldest first.
    logic                        rd_en;
    logic [`SB_ADDR_W-1:0]       rd_addr;
    logic [`SB_DATA_W-1:0]       rd_data;

    storebuffer #(
        .SB_SIZE (`SB_SIZE)
    ) u_storebuffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .st_valid (st_valid),
        .st       (st),
        .st_ready (st_ready),
        .wr_valid (wr_valid),
        .wr       (wr),
        .wr_ready (wr_ready),
        .entries  (entries)
    );

    load_unit u_load_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_valid  (ld_valid),
        .ld        (ld),
        .entries   (entries),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    data_ram u_data_ram (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .wr_valid (wr_valid),
        .wr       (wr),
        .wr_ready (wr_ready)
    );

endmodule

`default_nettype wire

// ==== test/tb_cases.svh ====
// Full words go in and drain during idle cycles; later loads read them from the RAM.
add_row("drain", 1, 6'h01, 32'h1111_1111, 4'hf, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("drain", 1, 6'h02, 32'h2222_2222, 4'hf, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("drain", 1, 6'h03, 32'h3333_3333, 4'hf, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("drain", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("drain", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("drain", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h01, 0, 1, 32'h1111_1111, 4'h0);
add_row("drain", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("drain", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h03, 0, 1, 32'h3333_3333, 4'h0);
// Loads every cycle hold the stores in the buffer; the newer store wins byte 1.
add_row("forward", 1, 6'h01, 32'hAAAA_AAAA, 4'h3, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("forward", 1, 6'h01, 32'hBBBB_BBBB, 4'h6, 1, 6'h01, 0, 1, 32'h1111_AAAA, 4'h3);
add_row("forward", 1, 6'h04, 32'hCCDD_EEFF, 4'hf, 1, 6'h01, 0, 1, 32'h11BB_BBAA, 4'h7);
add_row("forward", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h04, 0, 1, 32'hCCDD_EEFF, 4'hf);
add_row("forward", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("forward", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("forward", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("forward", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h01, 0, 1, 32'h11BB_BBAA, 4'h0);
// The buffer fills under loads; the fifth store waits until a drain frees a slot.
add_row("backpressure", 1, 6'h08, 32'h8080_8080, 4'hf, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("backpressure", 1, 6'h09, 32'h9090_9090, 4'hf, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("backpressure", 1, 6'h0a, 32'hA0A0_A0A0, 4'hf, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("backpressure", 1, 6'h0b, 32'hB0B0_B0B0, 4'hf, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("backpressure", 1, 6'h0c, 32'hC0C0_C0C0, 4'hf, 1, 6'h02, 0, 0, 32'h2222_2222, 4'h0);
add_row("backpressure", 1, 6'h0c, 32'hC0C0_C0C0, 4'hf, 0, 6'h00, 0, 0, 32'h0000_0000, 4'h0);
add_row("backpressure", 1, 6'h0c, 32'hC0C0_C0C0, 4'hf, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h08, 0, 1, 32'h8080_8080, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h09, 0, 1, 32'h9090_9090, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h0a, 0, 1, 32'hA0A0_A0A0, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h0b, 0, 1, 32'hB0B0_B0B0, 4'h0);
add_row("backpressure", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h0c, 0, 1, 32'hC0C0_C0C0, 4'h0);
// Stores held by loads are flushed, together with the store offered in the flush cycle.
add_row("flush", 1, 6'h03, 32'hDEAD_BEEF, 4'hf, 1, 6'h02, 0, 1, 32'h2222_2222, 4'h0);
add_row("flush", 1, 6'h04, 32'h1234_5678, 4'hf, 1, 6'h03, 0, 1, 32'hDEAD_BEEF, 4'hf);
add_row("flush", 1, 6'h08, 32'h0F0F_0F0F, 4'hf, 0, 6'h00, 1, 1, 32'h0000_0000, 4'h0);
add_row("flush", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("flush", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h03, 0, 1, 32'h3333_3333, 4'h0);
add_row("flush", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h04, 0, 1, 32'hCCDD_EEFF, 4'h0);
add_row("flush", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h08, 0, 1, 32'h8080_8080, 4'h0);
// Bytes 0 and 3 change while the middle bytes keep the old RAM word.
add_row("strobe", 1, 6'h0b, 32'h5A5A_5A5A, 4'h9, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("strobe", 0, 6'h00, 32'h0000_0000, 4'h0, 0, 6'h00, 0, 1, 32'h0000_0000, 4'h0);
add_row("strobe", 0, 6'h00, 32'h0000_0000, 4'h0, 1, 6'h0b, 0, 1, 32'h5AB0_B05A, 4'h0);

// ==== test/tb_store_unit.sv ====
`default_nettype none

`include "sb_defines.svh"

module tb_store_unit
    import sb_pkg::*;
();

    localparam int RSP_POLL_LIMIT = 8;  // Polls of 5 units stay inside the low clock phase.

    // One table row is one clock cycle of stimulus plus what the DUT should show.
    typedef struct packed {
        logic      st_valid;
        sb_entry_t st;
        logic      ld_valid;
        load_req_t ld;
        logic      flush;
        logic      exp_ready;
        load_rsp_t exp_rsp;  // Checked one cycle after the load.
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      st_valid;
    sb_entry_t st;
    logic      st_ready;
    logic      ld_valid;
    load_req_t ld;
    logic      rsp_valid;
    load_rsp_t rsp;

    row_t  rows [$];
    string names [$];
    int    value_errors;
    int    missing_rsp;

    store_unit dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .st_valid  (st_valid),
        .st        (st),
        .st_ready  (st_ready),
        .ld_valid  (ld_valid),
        .ld        (ld),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic add_row(
        input string                 name,
        input int                    st_v,
        input logic [`SB_ADDR_W-1:0] st_addr,
        input logic [`SB_DATA_W-1:0] st_data,
        input logic [`SB_STRB_W-1:0] st_strb,
        input int                    ld_v,
        input logic [`SB_ADDR_W-1:0] ld_addr,
        input int                    fl,
        input int                    exp_ready,
        input logic [`SB_DATA_W-1:0] exp_data,
        input logic [`SB_STRB_W-1:0] exp_mask
    );
        row_t r;
        r.st_valid         = (st_v != 0);
        r.st.addr          = st_addr;
        r.st.data          = st_data;
        r.st.strb          = st_strb;
        r.st.valid         = (st_v != 0);
        r.ld_valid         = (ld_v != 0);
        r.ld.addr          = ld_addr;
        r.flush            = (fl != 0);
        r.exp_ready        = (exp_ready != 0);
        r.exp_rsp.data     = exp_data;
        r.exp_rsp.fwd_mask = exp_mask;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Columns of each row: test name, store valid, address, data, strobe,
    // load valid, load address, flush, expected st_ready, expected load data and mask.
    task automatic build_table();
        `include "tb_cases.svh"
    endtask

    task automatic check_rsp(input string name, input load_rsp_t exp, input load_rsp_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected data %h mask %b, actual data %h mask %b",
                     name, exp.data, exp.fwd_mask, act.data, act.fwd_mask);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // rsp_valid comes from a flop, so polling during the low phase is race free.
    task automatic wait_rsp(input string name, output logic seen);
        seen = rsp_valid;
        for (int n = 0; n < RSP_POLL_LIMIT && !seen; n++) begin
            #5;
            seen = rsp_valid;
        end
        if (!seen) begin
            missing_rsp++;
            $display("Test %s: the load got no response in the cycle after it was issued",
                     name);
        end
    endtask

    task automatic drive_row(input row_t r);
        st_valid = r.st_valid;
        st       = r.st;
        ld_valid = r.ld_valid;
        ld       = r.ld;
        flush    = r.flush;
    endtask

    initial begin
        row_t      r;
        row_t      idle;
        logic      pending;
        string     pending_name;
        load_rsp_t pending_rsp;
        logic      seen;

        value_errors = 0;
        missing_rsp  = 0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        st_valid     = 1'b0;
        st           = '0;
        ld_valid     = 1'b0;
        ld           = '0;
        idle         = '0;
        pending      = 1'b0;
        pending_name = "";
        pending_rsp  = '0;
        seen         = 1'b0;
        build_table();

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset", "st_ready", 1'b1, st_ready);
        check_bit("reset", "rsp_valid", 1'b0, rsp_valid);

        foreach (rows[i]) begin
            @(negedge clk);
            r = rows[i];
            drive_row(r);
            check_bit(names[i], "st_ready", r.exp_ready, st_ready);
            if (pending) begin
                wait_rsp(pending_name, seen);
                if (seen) begin
                    check_rsp(pending_name, pending_rsp, rsp);
                end
            end else begin
                check_bit(names[i], "rsp_valid", 1'b0, rsp_valid);  // No load last cycle.
            end
            pending      = r.ld_valid;
            pending_name = names[i];
            pending_rsp  = r.exp_rsp;
        end

        // One more cycle picks up the response of a load in the last row.
        @(negedge clk);
        drive_row(idle);
        if (pending) begin
            wait_rsp(pending_name, seen);
            if (seen) begin
                check_rsp(pending_name, pending_rsp, rsp);
            end
        end

        $display("Summary: %0d rows, %0d value errors, %0d missing responses",
                 rows.size(), value_errors, missing_rsp);
        if (value_errors == 0 && missing_rsp == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
+incdir+test
verilog/sb_pkg.sv
verilog/storebuffer.sv
verilog/sb_forward.sv
verilog/load_unit.sv
verilog/data_ram.sv
verilog/store_unit.sv
test/tb_store_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_store_unit -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
